// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mask_alu_tb
RTL_TOP    := mask_alu
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mask_alu_checker.sv ====
// Result checker for the masked ALU
// Unmasks o_rd on each o_ready and compares it with the queued expectation

`timescale 1ns/100ps

module mask_alu_checker (
  input  logic                      g_clk,
  input  logic                      g_resetn,
  input  logic                      i_ready,
  input  mask_alu_pkg::share_pair_t i_rd,
  output int                        o_checks,
  output int                        o_value_errs,
  output int                        o_other_errs,
  output int                        o_pending
);
  import mask_alu_pkg::*;

  alu_op_t exp_op_q[$];
  word_t   exp_val_q[$];
  string   exp_name_q[$];
  int      checks      = 0;
  int      value_errs  = 0;
  int      other_errs  = 0;
  int      outstanding = 0;  // Requests queued and not yet answered

  assign o_checks     = checks;
  assign o_value_errs = value_errs;
  assign o_other_errs = other_errs;
  assign o_pending    = outstanding;

  function automatic word_t unmask(input alu_op_t op, input share_pair_t rd);
    if (op == op_b_xor || op == op_b_and || op == op_b_add || op == op_b_sub) begin
      return rd.s0 ^ rd.s1;  // Boolean sharing
    end
    return rd.s0 - rd.s1;
  endfunction

  // Queued by the driver as each request goes out
  task automatic expect_result(input alu_op_t op, input word_t value, input string name);
    exp_op_q.push_back(op);
    exp_val_q.push_back(value);
    exp_name_q.push_back(name);
    outstanding++;
  endtask

  always @(posedge g_clk) begin
    alu_op_t op;
    word_t   exp_val;
    word_t   act_val;
    string   name;
    if (g_resetn && i_ready) begin
      if (exp_op_q.size() == 0) begin
        other_errs++;
        $display("o_ready pulsed at %0t with no request outstanding", $time);
      end else begin
        op      = exp_op_q.pop_front();
        exp_val = exp_val_q.pop_front();
        name    = exp_name_q.pop_front();
        outstanding--;
        act_val = unmask(op, i_rd);
        checks++;
        if (act_val !== exp_val) begin
          value_errs++;
          $display("ERROR %s: expected %08h, actual %08h", name, exp_val, act_val);
        end
        if (op == op_a_mask && i_rd.s1 == '0) begin
          other_errs++;
          $display("Test %s left the mask share s1 at zero", name);
        end
      end
    end
  end

endmodule

// ==== bench/mask_alu_props.sv ====
// Handshake and reset assertions for the masked ALU
// Bound into the top level

`timescale 1ns/100ps

module mask_alu_props (
  input logic                   g_clk,
  input logic                   g_resetn,
  input logic                   i_valid,
  input mask_alu_pkg::alu_req_t i_req,
  input logic                   i_ready
);
  import mask_alu_pkg::*;

  logic bool_op;

  assign bool_op = (i_req.op == op_b_xor) || (i_req.op == op_b_and) ||
                   (i_req.op == op_b_add) || (i_req.op == op_b_sub);

  ready_low_in_reset: assert property (@(posedge g_clk) !g_resetn |-> !i_ready)
    else $error("o_ready high while reset is held");

  // Sequenced ops end with a single pulse
  ready_single_pulse: assert property (@(posedge g_clk) disable iff (!g_resetn)
    (i_ready && bool_op) |=> !(i_ready && bool_op))
    else $error("o_ready stayed high after a Boolean op finished");

  req_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
    (i_valid && !i_ready) |=> (i_valid && $stable(i_req)))
    else $error("Request dropped or changed before o_ready");

endmodule

// ==== bench/mask_alu_tb.sv ====
// Testbench for the two-share masked ALU
// Table-driven requests with random share splits, watchdog and final report

`timescale 1ns/100ps

module mask_alu_tb;
  import mask_alu_pkg::*;

  localparam int clk_half       = 20;  // 40 ns period
  localparam int reset_cycles   = 4;
  localparam int cycles_per_row = 10;
  localparam int random_rows    = 16;

  logic        g_clk = 1'b0;
  logic        g_resetn;
  logic        i_valid;
  alu_req_t    i_req;
  logic        o_ready;
  share_pair_t o_rd;

  int          checks;
  int          value_errs;
  int          other_errs;
  int          pending;
  int          missing;
  bit          table_built;

  // Stimulus table with one entry per request
  alu_op_t     tbl_op[$];
  word_t       tbl_a[$];
  word_t       tbl_b[$];
  word_t       tbl_exp[$];
  string       tbl_name[$];

  always #(clk_half) g_clk = ~g_clk;

  mask_alu DUT (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_req    (i_req),
    .o_ready  (o_ready),
    .o_rd     (o_rd)
  );

  mask_alu_checker u_checker (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_ready      (o_ready),
    .i_rd         (o_rd),
    .o_checks     (checks),
    .o_value_errs (value_errs),
    .o_other_errs (other_errs),
    .o_pending    (pending)
  );

  bind mask_alu mask_alu_props u_props (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_req    (i_req),
    .i_ready  (o_ready)
  );

  function automatic word_t plain_result(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      op_b_xor:           return a ^ b;
      op_b_and:           return a & b;
      op_b_add, op_a_add: return a + b;
      op_b_sub, op_a_sub: return a - b;
      default:            return a;  // Mask and remask keep the value
    endcase
  endfunction

  // Boolean shares XOR to the value and arithmetic shares subtract to it
  // Mask reads s0 only
  function automatic share_pair_t split_operand(input alu_op_t op, input word_t v);
    word_t       r;
    share_pair_t p;
    r = $urandom();
    if (op == op_b_xor || op == op_b_and || op == op_b_add || op == op_b_sub) begin
      p.s0 = r;
      p.s1 = v ^ r;
    end else if (op == op_a_mask) begin
      p.s0 = v;
      p.s1 = r;
    end else begin
      p.s0 = v + r;
      p.s1 = r;
    end
    return p;
  endfunction

  task automatic add_row(input alu_op_t op, input word_t a, input word_t b,
                         input word_t exp, input string name);
    tbl_op.push_back(op);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_exp.push_back(exp);
    tbl_name.push_back(name);
  endtask

  task automatic build_table();
    alu_op_t op;
    word_t   a;
    word_t   b;
    add_row(op_b_xor,    32'hffff_0000, 32'h0f0f_0f0f, 32'hf0f0_0f0f, "xor_corner");
    add_row(op_b_xor,    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, "xor_zero");
    add_row(op_b_and,    32'hffff_0000, 32'h0f0f_0f0f, 32'h0f0f_0000, "and_corner");
    add_row(op_b_and,    32'hffff_ffff, 32'h1234_5678, 32'h1234_5678, "and_ones");
    add_row(op_b_add,    32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, "badd_full_carry");
    add_row(op_b_add,    32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, "badd_sign");
    add_row(op_b_add,    32'h1234_5678, 32'h9abc_def0, 32'hacf1_3568, "badd_mixed");
    add_row(op_b_sub,    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, "bsub_zero_minus_one");
    add_row(op_b_sub,    32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, "bsub_borrow");
    add_row(op_b_sub,    32'h9abc_def0, 32'h1234_5678, 32'h8888_8878, "bsub_mixed");
    add_row(op_b_sub,    32'h5a5a_5a5a, 32'h5a5a_5a5a, 32'h0000_0000, "bsub_same");
    add_row(op_a_add,    32'hffff_ffff, 32'h0000_0002, 32'h0000_0001, "aadd_wrap");
    add_row(op_a_add,    32'h1234_5678, 32'h9abc_def0, 32'hacf1_3568, "aadd_mixed");
    add_row(op_a_sub,    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, "asub_zero_minus_one");
    add_row(op_a_sub,    32'h9abc_def0, 32'h1234_5678, 32'h8888_8878, "asub_mixed");
    add_row(op_a_mask,   32'hdead_beef, 32'h0000_0000, 32'hdead_beef, "amask_value");
    add_row(op_a_mask,   32'h0000_0000, 32'h0000_0000, 32'h0000_0000, "amask_zero");
    add_row(op_a_remask, 32'hcafe_f00d, 32'h0000_0000, 32'hcafe_f00d, "aremask_value");
    add_row(op_a_remask, 32'hffff_ffff, 32'h0000_0000, 32'hffff_ffff, "aremask_ones");
    // Random operands with the ops rotating so that requests of all kinds follow each other
    for (int i = 0; i < random_rows; i++) begin
      op = alu_op_t'(3'(i % 8));
      a  = $urandom();
      b  = $urandom();
      add_row(op, a, b, plain_result(op, a, b), $sformatf("rand_%s_%0d", op.name(), i));
    end
  endtask

  // Called on a rising edge, returns on the edge that saw o_ready
  task automatic apply_row(input int idx);
    alu_req_t req;
    req.op  = tbl_op[idx];
    req.rs1 = split_operand(tbl_op[idx], tbl_a[idx]);
    req.rs2 = split_operand(tbl_op[idx], tbl_b[idx]);
    u_checker.expect_result(tbl_op[idx], tbl_exp[idx], tbl_name[idx]);
    i_valid <= 1'b1;
    i_req   <= req;
    do begin
      @(posedge g_clk);
    end while (!o_ready);
  endtask

  initial begin
    g_resetn = 1'b0;
    repeat (reset_cycles) @(posedge g_clk);
    g_resetn <= 1'b1;
  end

  initial begin
    void'($urandom(32'h191c));
    i_valid  = 1'b0;
    i_req    = '0;
    missing  = 0;
    build_table();
    table_built = 1'b1;
    // The first row is a Boolean XOR, presented while reset is still held
    @(posedge g_clk);
    for (int i = 0; i < tbl_op.size(); i++) begin
      apply_row(i);
      if (i % 4 == 3) begin
        i_valid <= 1'b0;  // Idle cycle between groups
        @(posedge g_clk);
      end
    end
    i_valid <= 1'b0;
    repeat (3) @(posedge g_clk);
    if (pending != 0) begin
      missing = pending;
      $display("%0d requests finished without a result reaching the checker", pending);
    end
    $display("Checks %0d, value errors %0d, other errors %0d, missing results %0d",
             checks, value_errs, other_errs, missing);
    if (value_errs + other_errs + missing == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (table_built);
    repeat (reset_cycles + tbl_op.size() * cycles_per_row) @(posedge g_clk);
    $display("Watchdog expired, the DUT stopped answering requests");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== boolean/mask_addsub.sv ====
// Masked Boolean add/subtract
// Kogge-Stone propagate/generate iteration over two shares, then the sum

`timescale 1ns/100ps

module mask_addsub (
  input  logic                      g_clk,
  input  logic                      g_resetn,
  input  logic                      i_ena,
  input  logic                      i_sub,
  input  mask_alu_pkg::word_t       i_gs,
  input  mask_alu_pkg::share_pair_t i_p,  // a ^ b from the logic stage
  input  mask_alu_pkg::share_pair_t i_g,  // a & b from the logic stage
  output mask_alu_pkg::share_pair_t o_s,
  output logic                      o_rdy
);
  import mask_alu_pkg::*;

  step_t       step_q;
  logic        first;
  word_t       gs_i;
  share_pair_t g_corr;
  share_pair_t p_i;
  share_pair_t g_i;
  share_pair_t pj;
  share_pair_t gj;
  share_pair_t tg_a_q;
  share_pair_t tg_b_q;
  share_pair_t tp_a_q;
  share_pair_t tp_b_q;
  share_pair_t p_q;
  share_pair_t g_q;
  share_pair_t post;

  function automatic share_pair_t shl_pair(input share_pair_t x, input int unsigned n);
    share_pair_t r;
    r.s0 = x.s0 << n;
    r.s1 = x.s1 << n;
    return r;
  endfunction

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      step_q <= step_first;
    end else if (o_rdy) begin
      step_q <= step_first;
    end else if (i_ena) begin
      step_q <= step_q + step_t'(1);
    end
  end

  assign o_rdy = (step_q == step_last);
  assign first = i_ena && (step_q == step_first);

  // Carry-in of a subtract folded into the bit 0 generate
  assign g_corr.s0 = {i_g.s0[xlen-1:1], i_g.s0[0] ^ (i_p.s0[0] & i_sub)};
  assign g_corr.s1 = {i_g.s1[xlen-1:1], i_g.s1[0] ^ (i_p.s1[0] & i_sub)};

  assign p_i  = first ? i_p : p_q;
  assign g_i  = first ? g_corr : g_q;
  assign gs_i = first ? i_gs : p_q.s0;  // Later steps guard with p0

  always_comb begin
    gj = '0;
    pj = '0;
    case (step_q)
      3'd1: begin
        gj = shl_pair(g_i, 1);
        pj = shl_pair(p_i, 1);
      end
      3'd2: begin
        gj = shl_pair(g_i, 2);
        pj = shl_pair(p_i, 2);
      end
      3'd3: begin
        gj = shl_pair(g_i, 4);
        pj = shl_pair(p_i, 4);
      end
      3'd4: begin
        gj = shl_pair(g_i, 8);
        pj = shl_pair(p_i, 8);
      end
      3'd5: gj = shl_pair(g_i, 16);  // Last propagate no longer needed
      default: ;
    endcase
  end

  // G' = G ^ (P & Gj), P' = P & Pj, each as four registered terms
  always_ff @(posedge g_clk) begin
    if (i_ena) begin
      tg_a_q.s0 <= g_i.s0 ^ (gj.s0 & p_i.s0);
      tg_a_q.s1 <= g_i.s1 ^ (gj.s1 & p_i.s0);
      tg_b_q.s0 <= gj.s0 & p_i.s1;
      tg_b_q.s1 <= gj.s1 & p_i.s1;
      tp_a_q.s0 <= gs_i ^ (p_i.s0 & pj.s0);
      tp_a_q.s1 <= gs_i ^ (p_i.s0 & pj.s1);
      tp_b_q.s0 <= p_i.s1 & pj.s0;
      tp_b_q.s1 <= p_i.s1 & pj.s1;
    end
  end

  assign g_q = tg_a_q ^ tg_b_q;
  assign p_q = tp_a_q ^ tp_b_q;

  // Sum = P ^ (carries << 1), i_sub enters as carry into bit 0
  assign post.s0 = i_p.s0 ^ {g_q.s0[xlen-2:0], 1'b0};
  assign post.s1 = i_p.s1 ^ {g_q.s1[xlen-2:0], i_sub};

  assign o_s = (o_rdy || step_q == step_first) ? post : '0;

endmodule

// ==== boolean/mask_logic.sv ====
// Threshold-implementation masked XOR and AND
// One register stage, cross products refreshed by a guard share

`timescale 1ns/100ps

module mask_logic (
  input  logic                      g_clk,
  input  logic                      g_resetn,
  input  logic                      i_ena,
  input  mask_alu_pkg::word_t       i_gs,
  input  mask_alu_pkg::share_pair_t i_a,
  input  mask_alu_pkg::share_pair_t i_b,
  output mask_alu_pkg::share_pair_t o_xor,
  output mask_alu_pkg::share_pair_t o_and,
  output mask_alu_pkg::word_t       o_gs,
  output logic                      o_rdy
);
  import mask_alu_pkg::*;

  share_pair_t xor_q;
  word_t       t0_q;  // gs ^ a0.b0
  word_t       t1_q;  // gs ^ a0.b1
  word_t       t2_q;
  word_t       t3_q;

  // Share-wise XOR and the four cross terms, all captured together
  always_ff @(posedge g_clk) begin
    if (i_ena) begin
      xor_q.s0 <= i_a.s0 ^ i_b.s0;
      xor_q.s1 <= i_a.s1 ^ i_b.s1;
      t0_q     <= i_gs ^ (i_a.s0 & i_b.s0);
      t1_q     <= i_gs ^ (i_a.s0 & i_b.s1);
      t2_q     <= i_a.s1 & i_b.s0;
      t3_q     <= i_a.s1 & i_b.s1;
    end
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_rdy <= 1'b0;
    end else begin
      o_rdy <= i_ena;  // Fixed one-cycle latency
    end
  end

  assign o_xor    = xor_q;
  assign o_and.s0 = t0_q ^ t2_q;  // Guard cancels across the two shares
  assign o_and.s1 = t1_q ^ t3_q;

  // Share a1 is independent of the AND shares, reused as the next guard
  assign o_gs = i_a.s1;

endmodule

// ==== common/mask_alu_pkg.sv ====
// Masked ALU shared definitions
// Share types, operation codes, add/sub step bounds and LFSR constants

package mask_alu_pkg;

  localparam int unsigned xlen = 32;  // Datapath width

  // One share, or one word of randomness
  typedef logic [xlen-1:0] word_t;

  // Boolean: value = s0 ^ s1, arithmetic: value = s0 - s1
  typedef struct packed {
    word_t s0;
    word_t s1;
  } share_pair_t;

  typedef enum logic [2:0] {
    op_b_xor    = 3'd0,
    op_b_and    = 3'd1,
    op_b_add    = 3'd2,
    op_b_sub    = 3'd3,
    op_a_add    = 3'd4,
    op_a_sub    = 3'd5,
    op_a_mask   = 3'd6,
    op_a_remask = 3'd7
  } alu_op_t;

  // 3 + 64 + 64 bits
  typedef struct packed {
    alu_op_t     op;
    share_pair_t rs1;
    share_pair_t rs2;
  } alu_req_t;

  // Kogge-Stone iteration step
  typedef logic [2:0] step_t;

  localparam step_t step_first = 3'd1;  // Loads the logic stage result
  localparam step_t step_last  = 3'd6;  // Carries resolved

  localparam word_t prng_seed = 32'h6789_abcd;
  // Bits 31, 21, 1 and 0, folded with XNOR
  localparam word_t prng_taps = 32'h8020_0003;

endpackage

// ==== design/arith_mask.sv ====
// Arithmetic masked add, subtract, mask and remask
// Per-share 33-bit adders, low bit forced so the carry-in comes from the op

`timescale 1ns/100ps

module arith_mask (
  input  mask_alu_pkg::share_pair_t i_a,
  input  mask_alu_pkg::share_pair_t i_b,
  input  mask_alu_pkg::word_t       i_gs,
  input  mask_alu_pkg::alu_op_t     i_op,
  output mask_alu_pkg::share_pair_t o_r
);
  import mask_alu_pkg::*;

  logic            do_add;
  logic            do_sub;
  logic            do_mask;
  logic            do_remask;
  word_t           rhs0;
  word_t           lhs1;
  word_t           rhs1;
  logic [xlen:0]   sum0;
  logic [xlen:0]   sum1;

  assign do_add    = (i_op == op_a_add);
  assign do_sub    = (i_op == op_a_sub);
  assign do_mask   = (i_op == op_a_mask);
  assign do_remask = (i_op == op_a_remask);

  // Subtract uses ~b plus one, mask/remask add the random word
  assign rhs0 = do_add ? i_b.s0 : do_sub ? ~i_b.s0 : i_gs;
  assign lhs1 = do_mask ? i_gs : i_a.s1;
  assign rhs1 = do_add ? i_b.s1 :
                do_sub ? ~i_b.s1 :
                do_remask ? i_gs : '0;

  assign sum0 = {i_a.s0, 1'b1} + {rhs0, do_sub};
  assign sum1 = {lhs1, 1'b1} + {rhs1, do_sub};

  assign o_r.s0 = sum0[xlen:1];
  assign o_r.s1 = sum1[xlen:1];

endmodule

// ==== design/mask_alu.sv ====
// Two-share masked ALU
// Decodes the request, runs the Boolean and arithmetic datapaths, muxes shares

`timescale 1ns/100ps

module mask_alu (
  input  logic                      g_clk,
  input  logic                      g_resetn,
  input  logic                      i_valid,
  input  mask_alu_pkg::alu_req_t    i_req,
  output logic                      o_ready,
  output mask_alu_pkg::share_pair_t o_rd
);
  import mask_alu_pkg::*;

  logic        sel_xor;
  logic        sel_and;
  logic        sel_add;
  logic        sel_sub;
  logic        sel_arith;
  logic        do_logic;
  logic        do_addsub;
  logic        logic_ena;
  logic        logic_rdy;
  logic        addsub_ena;
  logic        addsub_rdy;
  word_t       prng;
  word_t       prng_next;
  word_t       logic_gs;
  share_pair_t opnd_b;
  share_pair_t xor_pair;
  share_pair_t xor_fold;
  share_pair_t and_pair;
  share_pair_t addsub_pair;
  share_pair_t arith_pair;

  assign sel_xor   = (i_req.op == op_b_xor);
  assign sel_and   = (i_req.op == op_b_and);
  assign sel_add   = (i_req.op == op_b_add);
  assign sel_sub   = (i_req.op == op_b_sub);
  assign sel_arith = !(sel_xor || sel_and || sel_add || sel_sub);
  assign do_addsub = sel_add || sel_sub;
  assign do_logic  = sel_xor || sel_and || do_addsub;  // Add/sub start from a ^ b, a & b

  // a - b computed as a + ~b + 1, inverting one share of b inverts b
  assign opnd_b.s0 = i_req.rs2.s0;
  assign opnd_b.s1 = sel_sub ? ~i_req.rs2.s1 : i_req.rs2.s1;

  mask_prng u_prng (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .i_advance   (o_ready),   // Fresh randomness per operation
    .o_prng      (prng),
    .o_prng_next (prng_next)
  );

  mask_alu_ctl u_ctl (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_valid      (i_valid),
    .i_do_logic   (do_logic),
    .i_do_addsub  (do_addsub),
    .i_logic_rdy  (logic_rdy),
    .i_addsub_rdy (addsub_rdy),
    .o_logic_ena  (logic_ena),
    .o_addsub_ena (addsub_ena),
    .o_ready      (o_ready)
  );

  mask_logic u_logic (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_ena    (logic_ena),
    .i_gs     (prng_next),
    .i_a      (i_req.rs1),
    .i_b      (opnd_b),
    .o_xor    (xor_pair),
    .o_and    (and_pair),
    .o_gs     (logic_gs),
    .o_rdy    (logic_rdy)
  );

  mask_addsub u_addsub (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_ena    (addsub_ena),
    .i_sub    (sel_sub),
    .i_gs     (logic_gs),
    .i_p      (xor_pair),
    .i_g      (and_pair),
    .o_s      (addsub_pair),
    .o_rdy    (addsub_rdy)
  );

  arith_mask u_arith (
    .i_a  (i_req.rs1),
    .i_b  (i_req.rs2),
    .i_gs (prng),
    .i_op (i_req.op),
    .o_r  (arith_pair)
  );

  // XOR result gets remasked with the same word on both shares
  assign xor_fold.s0 = prng_next ^ xor_pair.s0;
  assign xor_fold.s1 = prng_next ^ xor_pair.s1;

  assign o_rd = ({2*xlen{sel_xor}}   & xor_fold)    |
                ({2*xlen{sel_and}}   & and_pair)    |
                ({2*xlen{do_addsub}} & addsub_pair) |
                ({2*xlen{sel_arith}} & arith_pair);

endmodule

// ==== design/mask_alu_ctl.sv ====
// Masked ALU sequencer
// Orders the logic stage and the add/sub iteration, raises o_ready

`timescale 1ns/100ps

module mask_alu_ctl (
  input  logic g_clk,
  input  logic g_resetn,
  input  logic i_valid,
  input  logic i_do_logic,
  input  logic i_do_addsub,
  input  logic i_logic_rdy,
  input  logic i_addsub_rdy,
  output logic o_logic_ena,
  output logic o_addsub_ena,
  output logic o_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_logic,   // Logic stage result being taken
    st_arith    // Add/sub iteration running
  } ctl_state_t;

  ctl_state_t state_q;
  ctl_state_t state_d;
  logic       logic_go;
  logic       addsub_go;

  assign logic_go  = i_valid && i_do_logic;
  assign addsub_go = i_valid && i_do_addsub;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (logic_go) begin
          if (!i_logic_rdy) begin
            state_d = st_logic;
          end else if (addsub_go) begin
            state_d = st_arith;
          end
        end
      end
      st_logic: state_d = addsub_go ? st_arith : st_idle;
      st_arith: state_d = i_addsub_rdy ? st_idle : st_arith;
      default:  state_d = st_idle;
    endcase
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign o_logic_ena  = logic_go && (state_q == st_idle);
  assign o_addsub_ena = addsub_go && (state_q != st_idle || i_logic_rdy);

  // Arithmetic ops finish in the request cycle
  assign o_ready = (i_valid && !i_do_logic) ||
                   (logic_go && !i_do_addsub && i_logic_rdy) ||
                   (addsub_go && i_addsub_rdy);

endmodule

// ==== design/mask_prng.sv ====
// Mask randomness source
// 32-bit Fibonacci LFSR, steps once per finished operation

`timescale 1ns/100ps

module mask_prng (
  input  logic                g_clk,
  input  logic                g_resetn,
  input  logic                i_advance,
  output mask_alu_pkg::word_t o_prng,
  output mask_alu_pkg::word_t o_prng_next
);
  import mask_alu_pkg::*;

  word_t lfsr_q;
  logic  feedback;

  assign feedback    = ~^(lfsr_q & prng_taps);  // XNOR of the tapped bits
  assign o_prng_next = {lfsr_q[xlen-2:0], feedback};
  assign o_prng      = lfsr_q;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      lfsr_q <= prng_seed;
    end else if (i_advance) begin
      lfsr_q <= o_prng_next;
    end
  end

endmodule

// ==== project.f ====
common/mask_alu_pkg.sv
design/mask_prng.sv
design/mask_alu_ctl.sv
boolean/mask_logic.sv
boolean/mask_addsub.sv
design/arith_mask.sv
design/mask_alu.sv
bench/mask_alu_props.sv
bench/mask_alu_checker.sv
bench/mask_alu_tb.sv
